// ==== hw/uart_pkg.sv ====
/* UART shared definitions */

`default_nettype none

package uart_pkg;

	// --------------------------------------------------------------------------
	// frame layout
	// --------------------------------------------------------------------------
	// 8N1 framing
	localparam int UART_DATA_W     = 8;
	localparam int UART_FRAME_BITS = UART_DATA_W + 2;

	// oversampling per bit
	localparam int UART_OVERSAMPLE = 16;
	localparam int UART_PHASE_W    = $clog2(UART_OVERSAMPLE);
	localparam int UART_BIT_CNT_W  = $clog2(UART_FRAME_BITS);

	// mid bit sample point
	localparam logic [UART_PHASE_W-1:0] UART_MID_SAMPLE = UART_PHASE_W'(7);
	// last enable of a bit period
	localparam logic [UART_PHASE_W-1:0] UART_PHASE_LAST = UART_PHASE_W'(UART_OVERSAMPLE - 1);
	// stop bit position, start bit is 0
	localparam logic [UART_BIT_CNT_W-1:0] UART_STOP_IDX = UART_BIT_CNT_W'(UART_FRAME_BITS - 1);

	// --------------------------------------------------------------------------
	// baud divider
	// --------------------------------------------------------------------------
	// clocks per 16x enable
	localparam int UART_BAUD_DIV   = 4;
	localparam int UART_BAUD_CNT_W = $clog2(UART_BAUD_DIV);
	localparam logic [UART_BAUD_CNT_W-1:0] UART_BAUD_LOAD = UART_BAUD_CNT_W'(UART_BAUD_DIV - 1);

	// --------------------------------------------------------------------------
	// receive FIFO
	// --------------------------------------------------------------------------
	// power of two so pointers wrap on their own
	localparam int UART_RX_FIFO_DEPTH = 4;
	localparam int UART_RX_PTR_W      = $clog2(UART_RX_FIFO_DEPTH);
	localparam int UART_RX_CNT_W      = UART_RX_PTR_W + 1;

	// received byte plus stop bit check
	typedef struct packed {
		logic [UART_DATA_W-1:0] data;
		logic                   frame_err;
	} uart_rx_word_t;

endpackage

`default_nettype wire

// ==== hw/uart_baud_gen.sv ====
/* UART 16x baud enable */

`timescale 1ns/10ps
`default_nettype none

module uart_baud_gen
	import uart_pkg::*;
(
	input  wire  clk,
	input  wire  i_rst_n,
	// one clock pulse, 16 per bit
	output logic o_baud_16x_en
);

	// down counter, reloads on zero
	logic [UART_BAUD_CNT_W-1:0] div_cnt;

	// --------------------------------------------------------------------------
	// free running divider
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_cnt       <= UART_BAUD_LOAD;
			o_baud_16x_en <= 1'b0;
		end else begin
			if (div_cnt == '0) begin
				// wrap point, pulse once
				div_cnt       <= UART_BAUD_LOAD;
				o_baud_16x_en <= 1'b1;
			end else begin
				div_cnt       <= div_cnt - 1'b1;
				o_baud_16x_en <= 1'b0;
			end
		end
	end

	// enable is registered so rx and tx see the same edge
	// first pulse lands UART_BAUD_DIV clocks after reset release

endmodule

`default_nettype wire

// ==== hw/uart_rx_bit.sv ====
/* UART serial receiver */

`timescale 1ns/10ps
`default_nettype none

module uart_rx_bit
	import uart_pkg::*;
(
	input  wire           clk,
	input  wire           i_rst_n,
	input  wire           i_baud_16x_en,
	// asynchronous serial line
	input  wire           i_rx_ser,
	// one clock write strobe to the FIFO
	output logic          o_rx_wr,
	output uart_rx_word_t o_rx_word
);

	// synchroniser stages
	logic ser_d0;
	logic ser_d1;
	// line value at the previous enable
	logic sample0;
	logic rx_fall;
	// frame in progress
	logic rx_busy;
	logic [UART_PHASE_W-1:0]   phase_cnt;
	logic [UART_BIT_CNT_W-1:0] bit_cnt;
	logic [UART_DATA_W-1:0]    shift_reg;
	logic mid_tick;

	// --------------------------------------------------------------------------
	// line synchroniser
	// --------------------------------------------------------------------------
	// idle line is high
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ser_d0 <= 1'b1;
			ser_d1 <= 1'b1;
		end else begin
			ser_d0 <= i_rx_ser;
			ser_d1 <= ser_d0;
		end
	end

	// sampled at the enable rate for edge detection
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sample0 <= 1'b1;
		end else if (i_baud_16x_en) begin
			sample0 <= ser_d1;
		end
	end

	// high to low between two enables
	assign rx_fall  = sample0 & ~ser_d1;
	// centre of the current bit
	assign mid_tick = rx_busy & i_baud_16x_en & (phase_cnt == UART_MID_SAMPLE);

	// --------------------------------------------------------------------------
	// phase and bit counters
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_busy   <= 1'b0;
			phase_cnt <= '0;
			bit_cnt   <= '0;
			o_rx_wr   <= 1'b0;
		end else begin
			o_rx_wr <= 1'b0;
			if (i_baud_16x_en) begin
				if (!rx_busy) begin
					// waiting for a start edge
					if (rx_fall) begin
						rx_busy   <= 1'b1;
						phase_cnt <= UART_PHASE_W'(1);
						bit_cnt   <= '0;
					end
				end else begin
					// 16 enables per bit, wraps by width
					phase_cnt <= phase_cnt + 1'b1;
					if (phase_cnt == UART_PHASE_LAST) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
					// stop bit centre ends the frame
					if (phase_cnt == UART_MID_SAMPLE && bit_cnt == UART_STOP_IDX) begin
						rx_busy <= 1'b0;
						o_rx_wr <= 1'b1;
					end
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// data capture
	// --------------------------------------------------------------------------
	// bit 0 is the start bit and is not stored
	always_ff @(posedge clk) begin
		if (mid_tick) begin
			if (bit_cnt == UART_STOP_IDX) begin
				o_rx_word.data      <= shift_reg;
				// stop bit must be high
				o_rx_word.frame_err <= ~ser_d1;
			end else if (bit_cnt != '0) begin
				// lsb first
				shift_reg <= {ser_d1, shift_reg[UART_DATA_W-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx_bit.sv ====
/* UART serial transmitter */

`timescale 1ns/10ps
`default_nettype none

module uart_tx_bit
	import uart_pkg::*;
(
	input  wire                   clk,
	input  wire                   i_rst_n,
	input  wire                   i_baud_16x_en,
	// host side, four phase
	input  wire                   i_tx_req,
	input  wire [UART_DATA_W-1:0] i_tx_data,
	output logic                  o_tx_ack,
	// serial line, high when idle
	output logic                  o_tx_ser
);

	// frame on the line
	logic tx_busy;
	logic [UART_PHASE_W-1:0]    phase_cnt;
	logic [UART_BIT_CNT_W-1:0]  bit_cnt;
	// stop, data, start with start in bit 0
	logic [UART_FRAME_BITS-1:0] frame_sr;
	// new byte taken this clock
	logic accept;
	// first enable of a bit period
	logic bit_start;

	// only when idle and the last handshake has closed
	assign accept    = i_tx_req & ~o_tx_ack & ~tx_busy;
	assign bit_start = tx_busy & i_baud_16x_en & (phase_cnt == '0);

	// --------------------------------------------------------------------------
	// host handshake
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tx_ack <= 1'b0;
		end else if (accept) begin
			o_tx_ack <= 1'b1;
		end else if (!i_tx_req) begin
			// req gone, close the handshake
			o_tx_ack <= 1'b0;
		end
	end

	// --------------------------------------------------------------------------
	// bit timing and line driver
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			tx_busy   <= 1'b0;
			phase_cnt <= '0;
			bit_cnt   <= '0;
			o_tx_ser  <= 1'b1;
		end else if (accept) begin
			// start bit goes out on the next enable
			tx_busy   <= 1'b1;
			phase_cnt <= '0;
			bit_cnt   <= '0;
		end else if (!tx_busy) begin
			o_tx_ser <= 1'b1;
		end else if (i_baud_16x_en) begin
			phase_cnt <= phase_cnt + 1'b1;
			if (phase_cnt == '0) begin
				o_tx_ser <= frame_sr[0];
			end
			if (phase_cnt == UART_PHASE_LAST) begin
				bit_cnt <= bit_cnt + 1'b1;
				// end of stop bit frees the transmitter
				if (bit_cnt == UART_STOP_IDX) begin
					tx_busy <= 1'b0;
				end
			end
		end
	end

	// frame shift register, ones fill from the top
	always_ff @(posedge clk) begin
		if (accept) begin
			frame_sr <= {1'b1, i_tx_data, 1'b0};
		end else if (bit_start) begin
			frame_sr <= {1'b1, frame_sr[UART_FRAME_BITS-1:1]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_rx_fifo.sv ====
/* UART receive FIFO */

`timescale 1ns/10ps
`default_nettype none

module uart_rx_fifo
	import uart_pkg::*;
(
	input  wire                    clk,
	input  wire                    i_rst_n,
	// write side from the receiver, no back-pressure
	input  wire                    i_wr,
	input  wire uart_rx_word_t     i_word,
	// host side, four phase
	output logic                   o_rx_req,
	output logic [UART_DATA_W-1:0] o_rx_data,
	output logic                   o_rx_frame_err,
	input  wire                    i_rx_ack,
	// sticky until reset
	output logic                   o_rx_overrun
);

	// handshake phases
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,
		HS_WAIT
	} hs_state_e;

	uart_rx_word_t mem [UART_RX_FIFO_DEPTH];
	logic [UART_RX_PTR_W-1:0] wr_ptr;
	logic [UART_RX_PTR_W-1:0] rd_ptr;
	logic [UART_RX_CNT_W-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic pop;
	hs_state_e hs_state;

	assign full  = (count == UART_RX_CNT_W'(UART_RX_FIFO_DEPTH));
	assign empty = (count == '0);
	// a write into a full buffer is lost
	assign push  = i_wr & ~full;
	assign pop   = (hs_state == HS_REQ) & i_rx_ack;

	// --------------------------------------------------------------------------
	// storage and pointers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= i_word;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			o_rx_overrun <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
			if (i_wr && full) begin
				o_rx_overrun <= 1'b1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// host handshake
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hs_state <= HS_IDLE;
		end else begin
			case (hs_state)
				// new req only after ack has dropped
				HS_IDLE: if (!empty && !i_rx_ack) hs_state <= HS_REQ;
				HS_REQ:  if (i_rx_ack) hs_state <= HS_WAIT;
				HS_WAIT: if (!i_rx_ack) hs_state <= HS_IDLE;
				default: hs_state <= HS_IDLE;
			endcase
		end
	end

	// head word holds while req is up
	assign o_rx_req       = (hs_state == HS_REQ);
	assign o_rx_data      = mem[rd_ptr].data;
	assign o_rx_frame_err = mem[rd_ptr].frame_err;

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
/* UART subsystem top */

`timescale 1ns/10ps
`default_nettype none

module uart_top
	import uart_pkg::*;
(
	input  wire                    clk,
	input  wire                    i_rst_n,
	// serial pins
	input  wire                    i_rx_ser,
	output logic                   o_tx_ser,
	// transmit host port
	input  wire                    i_tx_req,
	input  wire [UART_DATA_W-1:0]  i_tx_data,
	output logic                   o_tx_ack,
	// receive host port
	output logic                   o_rx_req,
	output logic [UART_DATA_W-1:0] o_rx_data,
	output logic                   o_rx_frame_err,
	input  wire                    i_rx_ack,
	output logic                   o_rx_overrun
);

	// shared 16x enable
	logic          baud_16x_en;
	// receiver to FIFO
	logic          rx_wr;
	uart_rx_word_t rx_word;

	// --------------------------------------------------------------------------
	// timing source
	// --------------------------------------------------------------------------
	uart_baud_gen u_baud_gen (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.o_baud_16x_en (baud_16x_en)
	);

	// --------------------------------------------------------------------------
	// receive path
	// --------------------------------------------------------------------------
	uart_rx_bit u_rx_bit (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_baud_16x_en (baud_16x_en),
		.i_rx_ser      (i_rx_ser),
		.o_rx_wr       (rx_wr),
		.o_rx_word     (rx_word)
	);

	uart_rx_fifo u_rx_fifo (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_wr           (rx_wr),
		.i_word         (rx_word),
		.o_rx_req       (o_rx_req),
		.o_rx_data      (o_rx_data),
		.o_rx_frame_err (o_rx_frame_err),
		.i_rx_ack       (i_rx_ack),
		.o_rx_overrun   (o_rx_overrun)
	);

	// --------------------------------------------------------------------------
	// transmit path
	// --------------------------------------------------------------------------
	uart_tx_bit u_tx_bit (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_baud_16x_en (baud_16x_en),
		.i_tx_req      (i_tx_req),
		.i_tx_data     (i_tx_data),
		.o_tx_ack      (o_tx_ack),
		.o_tx_ser      (o_tx_ser)
	);

endmodule

`default_nettype wire

// ==== test/uart_clk_gen.sv ====
/* testbench clock source */

`timescale 1ns/10ps
`default_nettype none

module uart_clk_gen (
	output logic clk
);

	// 100 ns period, low at time zero
	initial begin
		clk = 1'b0;
	end

	always begin
		#50 clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== test/uart_assertions.sv ====
/* UART handshake and line assertions */

`timescale 1ns/10ps
`default_nettype none

module uart_assertions
	import uart_pkg::*;
(
	input wire                   clk,
	input wire                   i_rst_n,
	input wire                   i_tx_req,
	input wire                   o_tx_ack,
	input wire                   o_tx_ser,
	// transmitter frame in progress
	input wire                   i_tx_busy,
	input wire                   o_rx_req,
	input wire                   i_rx_ack,
	input wire [UART_DATA_W-1:0] o_rx_data
);

	// read back by the testbench at the end of the run
	int unsigned fail_cnt = 0;

	// --------------------------------------------------------------------------
	// transmit handshake
	// --------------------------------------------------------------------------
	a_tx_ack_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_tx_ack) |-> i_tx_req)
	else begin
		fail_cnt++;
		$error("tx ack rose while tx req was low");
	end

	a_tx_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_tx_req && !o_tx_ack |=> i_tx_req)
	else begin
		fail_cnt++;
		$error("tx req dropped before tx ack");
	end

	// --------------------------------------------------------------------------
	// receive handshake
	// --------------------------------------------------------------------------
	a_rx_ack_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_rx_ack) |-> o_rx_req)
	else begin
		fail_cnt++;
		$error("rx ack rose while rx req was low");
	end

	a_rx_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rx_req && !i_rx_ack |=> o_rx_req)
	else begin
		fail_cnt++;
		$error("rx req dropped before rx ack");
	end

	// head word must not move under a pending req
	a_rx_data_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rx_req && $past(o_rx_req) |-> $stable(o_rx_data))
	else begin
		fail_cnt++;
		$error("rx data changed while rx req was high");
	end

	// idle line is high
	a_tx_line_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
		!i_tx_busy |-> o_tx_ser)
	else begin
		fail_cnt++;
		$error("tx line low with no frame in progress");
	end

endmodule

bind uart_top uart_assertions u_assertions (
	.clk       (clk),
	.i_rst_n   (i_rst_n),
	.i_tx_req  (i_tx_req),
	.o_tx_ack  (o_tx_ack),
	.o_tx_ser  (o_tx_ser),
	.i_tx_busy (u_tx_bit.tx_busy),
	.o_rx_req  (o_rx_req),
	.i_rx_ack  (i_rx_ack),
	.o_rx_data (o_rx_data)
);

`default_nettype wire

// ==== test/uart_tb.sv ====
/* UART subsystem testbench */

`timescale 1ns/10ps
`default_nettype none

module uart_tb
	import uart_pkg::*;
();

	// --------------------------------------------------------------------------
	// run length
	// --------------------------------------------------------------------------
	localparam int BIT_CLKS       = UART_OVERSAMPLE * UART_BAUD_DIV;
	localparam int FRAME_CLKS     = UART_FRAME_BITS * BIT_CLKS;
	localparam int NUM_B2B        = 20;
	localparam int NUM_FERR       = 3;
	localparam int NUM_OVR        = 6;
	localparam int TOTAL_FRAMES   = 1 + NUM_B2B + NUM_FERR + NUM_OVR;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_CLKS + 2000;
	localparam int RND_SEED       = 19;
	// stop bit of each framing test frame with bit 0 sent first
	localparam logic [NUM_FERR-1:0] FERR_STOP = 3'b010;

	logic                   clk;
	logic                   i_rst_n;
	logic                   i_rx_ser;
	logic                   o_tx_ser;
	logic                   i_tx_req;
	logic [UART_DATA_W-1:0] i_tx_data;
	logic                   o_tx_ack;
	logic                   o_rx_req;
	logic [UART_DATA_W-1:0] o_rx_data;
	logic                   o_rx_frame_err;
	logic                   i_rx_ack;
	logic                   o_rx_overrun;

	// line mux select and testbench driven line
	logic use_loopback;
	logic ser_drv;
	// host holds back rx ack
	logic rx_hold;

	uart_rx_word_t exp_q[$];
	uart_rx_word_t got_word;
	int            rx_done = 0;
	int            err_cnt = 0;
	int            check_cnt = 0;
	int            test_cnt = 0;
	int            test_fail_cnt = 0;
	int            test_err_base = 0;
	string         test_name;
	int unsigned   cycle_cnt = 0;

	uart_clk_gen u_clk_gen (
		.clk (clk)
	);

	uart_top u_dut (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_rx_ser       (i_rx_ser),
		.o_tx_ser       (o_tx_ser),
		.i_tx_req       (i_tx_req),
		.i_tx_data      (i_tx_data),
		.o_tx_ack       (o_tx_ack),
		.o_rx_req       (o_rx_req),
		.o_rx_data      (o_rx_data),
		.o_rx_frame_err (o_rx_frame_err),
		.i_rx_ack       (i_rx_ack),
		.o_rx_overrun   (o_rx_overrun)
	);

	// loopback or driven frames
	assign i_rx_ser = use_loopback ? o_tx_ser : ser_drv;

	// --------------------------------------------------------------------------
	// reference model and checks
	// --------------------------------------------------------------------------
	// data is the byte as sent and a low stop bit is a framing error
	function automatic uart_rx_word_t expected_word(input logic [UART_DATA_W-1:0] data,
			input logic stop_bit);
		uart_rx_word_t w;
		w.data      = data;
		w.frame_err = ~stop_bit;
		return w;
	endfunction

	task automatic check_word(input string name, input uart_rx_word_t exp_w,
			input uart_rx_word_t act_w);
		check_cnt++;
		if (act_w !== exp_w) begin
			err_cnt++;
			$display("** Error at %0t ns: %s expected data=%h frame_err=%b, got data=%h frame_err=%b",
				$time, name, exp_w.data, exp_w.frame_err, act_w.data, act_w.frame_err);
		end
	endtask

	task automatic check_bit(input string name, input logic exp_b, input logic act_b);
		check_cnt++;
		if (act_b !== exp_b) begin
			err_cnt++;
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp_b, act_b);
		end
	endtask

	task automatic compare_received(input uart_rx_word_t got);
		uart_rx_word_t exp_w;
		if (exp_q.size() == 0) begin
			err_cnt++;
			$display("at %0t ns a byte %h arrived with nothing outstanding", $time, got.data);
		end else begin
			exp_w = exp_q.pop_front();
			check_word("o_rx_data/o_rx_frame_err", exp_w, got);
		end
		rx_done++;
	endtask

	// --------------------------------------------------------------------------
	// four phase receive host
	// --------------------------------------------------------------------------
	always @(posedge clk) begin
		if (i_rx_ack) begin
			// req gone so the handshake is complete
			if (!o_rx_req) begin
				i_rx_ack <= 1'b0;
				compare_received(got_word);
			end
		end else if (o_rx_req && !rx_hold) begin
			got_word.data      = o_rx_data;
			got_word.frame_err = o_rx_frame_err;
			i_rx_ack <= 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// stimulus tasks
	// --------------------------------------------------------------------------
	// transmit host that returns once ack has dropped
	task automatic tx_send(input logic [UART_DATA_W-1:0] data);
		i_tx_data <= data;
		i_tx_req  <= 1'b1;
		do @(posedge clk); while (!o_tx_ack);
		i_tx_req <= 1'b0;
		do @(posedge clk); while (o_tx_ack);
	endtask

	// start bit, data lsb first, stop bit and one idle bit
	task automatic drive_frame(input logic [UART_DATA_W-1:0] data, input logic stop_bit);
		logic [UART_FRAME_BITS-1:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < UART_FRAME_BITS; i++) begin
			ser_drv <= bits[i];
			repeat (BIT_CLKS) @(posedge clk);
		end
		ser_drv <= 1'b1;
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	task automatic wait_rx_done(input int target);
		while (rx_done < target) @(posedge clk);
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = err_cnt;
		test_cnt++;
	endtask

	task automatic end_test();
		if (exp_q.size() != 0) begin
			err_cnt++;
			$display("%0d expected bytes never arrived in %s", exp_q.size(), test_name);
		end
		if (err_cnt == test_err_base) begin
			$display("test %-16s passed", test_name);
		end else begin
			test_fail_cnt++;
			$display("test %-16s failed, %0d errors", test_name, err_cnt - test_err_base);
		end
	endtask

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------
	initial begin
		logic [UART_DATA_W-1:0] tx_byte;
		int base;
		void'($urandom(RND_SEED));
		i_rst_n      = 1'b0;
		i_tx_req     = 1'b0;
		i_tx_data    = '0;
		i_rx_ack     = 1'b0;
		ser_drv      = 1'b1;
		use_loopback = 1'b0;
		rx_hold      = 1'b0;
		repeat (16) @(posedge clk);
		i_rst_n <= 1'b1;
		@(posedge clk);

		begin_test("reset_state");
		check_bit("o_tx_ser", 1'b1, o_tx_ser);
		check_bit("o_tx_ack", 1'b0, o_tx_ack);
		check_bit("o_rx_req", 1'b0, o_rx_req);
		check_bit("o_rx_overrun", 1'b0, o_rx_overrun);
		end_test();

		begin_test("single_loopback");
		use_loopback <= 1'b1;
		base    = rx_done;
		tx_byte = 8'($urandom());
		exp_q.push_back(expected_word(tx_byte, 1'b1));
		tx_send(tx_byte);
		wait_rx_done(base + 1);
		end_test();

		// next req waits on the previous stop bit
		begin_test("b2b_loopback");
		base = rx_done;
		for (int i = 0; i < NUM_B2B; i++) begin
			tx_byte = 8'($urandom());
			exp_q.push_back(expected_word(tx_byte, 1'b1));
			tx_send(tx_byte);
		end
		wait_rx_done(base + NUM_B2B);
		end_test();

		begin_test("framing_error");
		use_loopback <= 1'b0;
		base = rx_done;
		for (int i = 0; i < NUM_FERR; i++) begin
			tx_byte = 8'($urandom());
			exp_q.push_back(expected_word(tx_byte, FERR_STOP[i]));
			drive_frame(tx_byte, FERR_STOP[i]);
		end
		wait_rx_done(base + NUM_FERR);
		end_test();

		// only the first DEPTH bytes fit
		begin_test("overrun");
		rx_hold <= 1'b1;
		@(posedge clk);
		check_bit("o_rx_overrun", 1'b0, o_rx_overrun);
		base = rx_done;
		for (int i = 0; i < NUM_OVR; i++) begin
			tx_byte = 8'($urandom());
			if (i < UART_RX_FIFO_DEPTH) begin
				exp_q.push_back(expected_word(tx_byte, 1'b1));
			end
			drive_frame(tx_byte, 1'b1);
		end
		check_bit("o_rx_overrun", 1'b1, o_rx_overrun);
		check_bit("o_rx_req", 1'b1, o_rx_req);
		rx_hold <= 1'b0;
		wait_rx_done(base + UART_RX_FIFO_DEPTH);
		repeat (8) @(posedge clk);
		check_bit("o_rx_req", 1'b0, o_rx_req);
		end_test();

		err_cnt = err_cnt + int'(u_dut.u_assertions.fail_cnt);
		$display("%0d tests, %0d failed, %0d checks, %0d errors (%0d from assertions)",
			test_cnt, test_fail_cnt, check_cnt, err_cnt, u_dut.u_assertions.fail_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// --------------------------------------------------------------------------
	// watchdog
	// --------------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, test %s did not finish", cycle_cnt, test_name);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx_bit.sv
hw/uart_tx_bit.sv
hw/uart_rx_fifo.sv
hw/uart_top.sv
test/uart_clk_gen.sv
test/uart_assertions.sv
test/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_subsystem

sources:
  # design, package first
  - files:
      - hw/uart_pkg.sv
      - hw/uart_baud_gen.sv
      - hw/uart_rx_bit.sv
      - hw/uart_tx_bit.sv
      - hw/uart_rx_fifo.sv
      - hw/uart_top.sv

  # testbench, top module uart_tb
  - target: test
    files:
      - test/uart_clk_gen.sv
      - test/uart_assertions.sv
      - test/uart_tb.sv
